// ==== tb.f ====
src/rv32i_pkg.sv
src/fetch_unit.sv
src/ctrl_rom.sv
src/regfile.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/datapath.sv
verif/datapath_properties.sv
verif/tb_datapath.sv

// ==== Bender.yml ====
package:
  name: rv32i_datapath

sources:
  - files:
      - src/rv32i_pkg.sv
      - src/fetch_unit.sv
      - src/ctrl_rom.sv
      - src/regfile.sv
      - src/execute_stage.sv
      - src/mem_wb_stage.sv
      - src/datapath.sv
  - target: test
    files:
      - verif/datapath_properties.sv
      - verif/tb_datapath.sv

// ==== verif/tb_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_datapath import rv32i_pkg::*; ();

  logic             clk;
  logic             rst_n;
  logic             icache_read;
  logic [XLEN-1:0]  icache_address;
  logic [XLEN-1:0]  icache_rdata;
  logic             icache_resp;
  logic             dcache_read;
  logic             dcache_write;
  logic [XLEN-1:0]  dcache_address;
  logic [XLEN-1:0]  dcache_wdata;
  logic [MBE_W-1:0] dcache_mbe;
  logic [XLEN-1:0]  dcache_rdata;
  logic             dcache_resp;

  logic [31:0] imem [1024];
  logic [31:0] dmem [512];
  logic [31:0] exp_addr [64];
  logic [31:0] exp_data [64];
  logic [3:0]  exp_mbe  [64];
  logic [31:0] last_addr;
  logic [31:0] last_wdata;
  logic [3:0]  last_mbe;
  logic        last_valid = 1'b0;
  int          n_words    = 0;
  int          n_exp      = 0;
  int          n_checked  = 0;
  int          errors     = 0;
  int          i_wait     = -1;
  int          d_wait     = -1;
  integer      seed       = 32'h22c5;

  datapath u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .icache_read    (icache_read),
    .icache_address (icache_address),
    .icache_rdata   (icache_rdata),
    .icache_resp    (icache_resp),
    .dcache_read    (dcache_read),
    .dcache_write   (dcache_write),
    .dcache_address (dcache_address),
    .dcache_wdata   (dcache_wdata),
    .dcache_mbe     (dcache_mbe),
    .dcache_rdata   (dcache_rdata),
    .dcache_resp    (dcache_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // RV32I instruction formats
  function automatic logic [31:0] i_type(input rv32i_opcode_t opc, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, op_lui};
  endfunction

  function automatic int draw_delay();
    return {$random(seed)} % 3;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] mbe);
    return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
  endfunction

  // Each instruction is followed by two no-ops to cover the dependency gap
  task automatic put_instr(input logic [31:0] word);
    imem[n_words]     = word;
    imem[n_words + 1] = i_type(op_imm, 5'd0, 3'b000, 5'd0, 12'h000);
    imem[n_words + 2] = i_type(op_imm, 5'd0, 3'b000, 5'd0, 12'h000);
    n_words           = n_words + 3;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mbe);
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    exp_mbe[n_exp]  = mbe;
    n_exp++;
  endtask

  task automatic build_program();
    logic [31:0] alu_exp [13];
    logic [2:0]  ld_f3   [13];
    logic [1:0]  ld_off  [13];
    logic [31:0] ld_exp  [13];
    logic [4:0]  sb_reg  [4];
    logic [31:0] sb_data [4];
    logic [3:0]  sb_mbe  [4];
    // Expected x2 through x14
    alu_exp = '{32'h1234_5678, 32'hffff_fff0, 32'h1234_5668, 32'h1234_5688, 32'h0000_0001,
                32'h0000_0000, 32'hedcb_a988, 32'hffff_fff8, 32'h1234_5670, 32'h0000_0001,
                32'h1234_5687, 32'hffff_ffff, 32'h0000_0670};
    ld_f3   = '{lb, lb, lb, lb, lbu, lbu, lbu, lbu, lh, lh, lhu, lhu, lw};
    ld_off  = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0, 2'd2, 2'd0};
    ld_exp  = '{32'h0000_005c, 32'h0000_006d, 32'h0000_007e, 32'hffff_ff8f,
                32'h0000_005c, 32'h0000_006d, 32'h0000_007e, 32'h0000_008f,
                32'h0000_6d5c, 32'hffff_8f7e, 32'h0000_6d5c, 32'h0000_8f7e, 32'h8f7e_6d5c};
    sb_reg  = '{5'd2, 5'd12, 5'd4, 5'd14};
    sb_data = '{32'h0000_0078, 32'h0000_8700, 32'h0068_0000, 32'h7000_0000};
    sb_mbe  = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
    for (int i = 0; i < 1024; i++) begin
      imem[i] = i_type(op_imm, 5'd0, 3'b000, 5'd0, 12'h000);
    end
    // Base pointer x1 = 0x200, then the ALU values
    put_instr(i_type(op_imm, 5'd1, 3'b000, 5'd0, 12'h200));
    put_instr(u_type(20'h12345, 5'd2));
    put_instr(i_type(op_imm, 5'd2, 3'b000, 5'd2, 12'h678));
    put_instr(i_type(op_imm, 5'd3, 3'b000, 5'd0, 12'hff0));
    put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
    put_instr(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));
    put_instr(r_type(7'h00, 5'd2, 5'd3, 3'b010, 5'd6));
    put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd7));
    put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8));
    put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd9));
    put_instr(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd10));
    put_instr(i_type(op_imm, 5'd11, 3'b010, 5'd3, 12'hff1));
    put_instr(i_type(op_imm, 5'd12, 3'b100, 5'd2, 12'h0ff));
    put_instr(i_type(op_imm, 5'd13, 3'b110, 5'd3, 12'h00f));
    put_instr(i_type(op_imm, 5'd14, 3'b111, 5'd2, 12'h7f0));
    for (int k = 2; k <= 14; k++) begin
      put_instr(s_type(sw, 5'(k), 5'd1, 12'(4 * k)));
      expect_store(32'h200 + 32'(4 * k), alu_exp[k - 2], 4'hf);
    end
    // Byte lanes of word 0x300, halfwords of word 0x304
    for (int o = 0; o < 4; o++) begin
      put_instr(s_type(sb, sb_reg[o], 5'd1, 12'h100 + 12'(o)));
      expect_store(32'h300, sb_data[o], sb_mbe[o]);
    end
    put_instr(s_type(sh, 5'd5, 5'd1, 12'h104));
    expect_store(32'h304, 32'h0000_5688, 4'b0011);
    put_instr(s_type(sh, 5'd8, 5'd1, 12'h106));
    expect_store(32'h304, 32'ha988_0000, 4'b1100);
    // Loads from the preloaded word at 0x400, each stored back at 0x500 on
    for (int i = 0; i < 13; i++) begin
      put_instr(i_type(op_load, 5'd16, ld_f3[i], 5'd1, 12'h200 + 12'(ld_off[i])));
      put_instr(s_type(sw, 5'd16, 5'd1, 12'h300 + 12'(4 * i)));
      expect_store(32'h500 + 32'(4 * i), ld_exp[i], 4'hf);
    end
  endtask

  task automatic init_dmem();
    for (int i = 0; i < 512; i++) begin
      dmem[i] = 32'h5a00_0000 ^ 32'(i << 2);
    end
    dmem[32'h400 >> 2] = 32'h8f7e_6d5c;
  endtask

  task automatic check_write();
    logic [31:0] mask;
    mask = lane_mask(dcache_mbe);
    if (n_checked >= n_exp) begin
      errors++;
      $display("[FAIL] %0t: unexpected data write to %h", $time, dcache_address);
    end else begin
      assert (dcache_address == exp_addr[n_checked] && dcache_mbe == exp_mbe[n_checked] &&
              (dcache_wdata & mask) == (exp_data[n_checked] & mask))
      else begin
        errors++;
        $display("[FAIL] %0t: write %0d got addr %h data %h mbe %b, expected %h %h %b",
                 $time, n_checked, dcache_address, dcache_wdata, dcache_mbe,
                 exp_addr[n_checked], exp_data[n_checked], exp_mbe[n_checked]);
      end
      n_checked++;
    end
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] expected);
    assert (dmem[addr[10:2]] == expected)
    else begin
      errors++;
      $display("[FAIL] %0t: memory word %h holds %h, expected %h",
               $time, addr, dmem[addr[10:2]], expected);
    end
  endtask

  task automatic serve_icache();
    icache_resp = 1'b0;
    if (icache_read) begin
      if (i_wait < 0) begin
        i_wait = draw_delay();
      end
      if (i_wait > 0) begin
        i_wait--;
      end else begin
        icache_rdata = imem[icache_address[11:2]];
        icache_resp  = 1'b1;
        i_wait       = -1;
      end
    end
  endtask

  task automatic serve_dcache();
    logic [8:0] idx;
    logic       reissued;
    dcache_resp = 1'b0;
    if (dcache_read || dcache_write) begin
      if (d_wait < 0) begin
        d_wait = draw_delay();
      end
      if (d_wait > 0) begin
        d_wait--;
      end else begin
        idx = dcache_address[10:2];
        if (dcache_write) begin
          // Same store again after its pulse means the pipeline was held by fetch
          reissued = last_valid && dcache_address == last_addr &&
                     dcache_wdata == last_wdata && dcache_mbe == last_mbe;
          if (!reissued) begin
            check_write();
          end
          for (int b = 0; b < 4; b++) begin
            if (dcache_mbe[b]) begin
              dmem[idx][8*b +: 8] = dcache_wdata[8*b +: 8];
            end
          end
          last_valid = 1'b1;
          last_addr  = dcache_address;
          last_wdata = dcache_wdata;
          last_mbe   = dcache_mbe;
        end else begin
          dcache_rdata = dmem[idx];
          last_valid   = 1'b0;
        end
        dcache_resp = 1'b1;
        d_wait      = -1;
      end
    end
  endtask

  // All inputs change 1 ns after the rising edge
  initial begin : drive_inputs
    int rst_cycles;
    rst_n        = 1'b0;
    icache_rdata = '0;
    icache_resp  = 1'b0;
    dcache_rdata = '0;
    dcache_resp  = 1'b0;
    rst_cycles   = 0;
    forever begin
      @(posedge clk);
      #1;
      serve_icache();
      serve_dcache();
      if (!rst_n) begin
        rst_cycles++;
        if (rst_cycles == 8) begin
          rst_n = 1'b1;
        end
      end
    end
  end

  initial begin : run_test
    int   cycles;
    logic timed_out;
    build_program();
    init_dmem();
    cycles = 0;
    while (n_checked < n_exp && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = (n_checked < n_exp);
    if (timed_out) begin
      $display("Timeout: only %0d of %0d data writes arrived within %0d cycles",
               n_checked, n_exp, cycles);
    end
    check_word(32'h300, 32'h7068_8778);
    check_word(32'h304, 32'ha988_5688);
    $display("Summary: %0d of %0d writes checked, %0d errors, %0d assertion failures",
             n_checked, n_exp, errors, u_dut.u_props.fail_count);
    if (!timed_out && errors == 0 && u_dut.u_props.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/datapath_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath_properties import rv32i_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             icache_read,
  input logic [XLEN-1:0]  icache_address,
  input logic             icache_resp,
  input logic             dcache_read,
  input logic             dcache_write,
  input logic [XLEN-1:0]  dcache_address,
  input logic [XLEN-1:0]  dcache_wdata,
  input logic [MBE_W-1:0] dcache_mbe,
  input logic             dcache_resp
);

  int unsigned fail_count = 0;

  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> !(icache_read || dcache_read || dcache_write))
  else begin
    fail_count++;
    $error("cache request high while reset is held");
  end

  a_dcache_exclusive: assert property (@(posedge clk) !(dcache_read && dcache_write))
  else begin
    fail_count++;
    $error("data cache read and write high together");
  end

  // Fetch held until its response
  a_icache_hold: assert property (@(posedge clk) disable iff (!rst_n)
    icache_read && !icache_resp |=> icache_read && $stable(icache_address))
  else begin
    fail_count++;
    $error("instruction request changed before its response");
  end

  a_dcache_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (dcache_read || dcache_write) && !dcache_resp |=>
      $stable({dcache_read, dcache_write, dcache_address, dcache_wdata, dcache_mbe}))
  else begin
    fail_count++;
    $error("data request changed before its response");
  end

endmodule

bind datapath datapath_properties u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .icache_read    (icache_read),
  .icache_address (icache_address),
  .icache_resp    (icache_resp),
  .dcache_read    (dcache_read),
  .dcache_write   (dcache_write),
  .dcache_address (dcache_address),
  .dcache_wdata   (dcache_wdata),
  .dcache_mbe     (dcache_mbe),
  .dcache_resp    (dcache_resp)
);

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath import rv32i_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,

  // Instruction cache
  output logic             icache_read,
  output logic [XLEN-1:0]  icache_address,
  input  logic [XLEN-1:0]  icache_rdata,
  input  logic             icache_resp,

  // Data cache
  output logic             dcache_read,
  output logic             dcache_write,
  output logic [XLEN-1:0]  dcache_address,
  output logic [XLEN-1:0]  dcache_wdata,
  output logic [MBE_W-1:0] dcache_mbe,
  input  logic [XLEN-1:0]  dcache_rdata,
  input  logic             dcache_resp
);

  logic            advance;
  logic            mem_busy;
  instr_t          ifid_instr;
  ctrl_word_t      ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  exmem_t          exmem;
  wb_t             wb;

  fetch_unit u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .icache_resp    (icache_resp),
    .icache_rdata   (icache_rdata),
    .mem_busy       (mem_busy),
    .icache_read    (icache_read),
    .icache_address (icache_address),
    .advance        (advance),
    .ifid_instr     (ifid_instr)
  );

  ctrl_rom u_ctrl_rom (
    .instr (ifid_instr),
    .ctrl  (ctrl)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb       (wb),
    .rs1_addr (ifid_instr.rs1),
    .rs2_addr (ifid_instr.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance  (advance),
    .instr    (ifid_instr),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .exmem    (exmem)
  );

  mem_wb_stage u_mem_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .advance        (advance),
    .exmem          (exmem),
    .dcache_rdata   (dcache_rdata),
    .dcache_resp    (dcache_resp),
    .dcache_read    (dcache_read),
    .dcache_write   (dcache_write),
    .dcache_address (dcache_address),
    .dcache_wdata   (dcache_wdata),
    .dcache_mbe     (dcache_mbe),
    .mem_busy       (mem_busy),
    .wb             (wb)
  );

endmodule

`default_nettype wire

// ==== src/mem_wb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage import rv32i_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance,
  input  exmem_t           exmem,
  input  logic [XLEN-1:0]  dcache_rdata,
  input  logic             dcache_resp,
  output logic             dcache_read,
  output logic             dcache_write,
  output logic [XLEN-1:0]  dcache_address,
  output logic [XLEN-1:0]  dcache_wdata,
  output logic [MBE_W-1:0] dcache_mbe,
  output logic             mem_busy,
  output wb_t              wb
);

  memwb_t          memwb_q;
  logic [1:0]      byte_off;
  logic [XLEN-1:0] byte_lane;
  logic [XLEN-1:0] half_lane;
  logic [XLEN-1:0] load_data;

  assign byte_off = exmem.alu_out[1:0];

  // Requests held low through reset, before EX/MEM is cleared
  assign dcache_read    = exmem.ctrl.dcache_read & rst_n;
  assign dcache_write   = exmem.ctrl.dcache_write & rst_n;
  assign dcache_address = {exmem.alu_out[XLEN-1:2], 2'b00};
  assign mem_busy       = (dcache_read | dcache_write) & ~dcache_resp;

  // Store lane steering
  always_comb begin
    dcache_wdata = '0;
    dcache_mbe   = '0;
    if (exmem.ctrl.dcache_write) begin
      case (store_funct3_t'(exmem.instr.funct3))
        sb: begin
          dcache_wdata = exmem.rs2_data << {byte_off, 3'b000};
          dcache_mbe   = MBE_W'(1) << byte_off;
        end
        sh: begin
          dcache_wdata = exmem.rs2_data << {byte_off[1], 4'b0000};
          dcache_mbe   = MBE_W'(3) << {byte_off[1], 1'b0};
        end
        default: begin
          dcache_wdata = exmem.rs2_data;
          dcache_mbe   = '1;
        end
      endcase
    end
  end

  // Load lane extraction
  assign byte_lane = dcache_rdata >> {byte_off, 3'b000};
  assign half_lane = dcache_rdata >> {byte_off[1], 4'b0000};

  always_comb begin
    case (load_funct3_t'(exmem.instr.funct3))
      lb:      load_data = {{24{byte_lane[7]}}, byte_lane[7:0]};
      lbu:     load_data = {24'h000000, byte_lane[7:0]};
      lh:      load_data = {{16{half_lane[15]}}, half_lane[15:0]};
      lhu:     load_data = {16'h0000, half_lane[15:0]};
      default: load_data = dcache_rdata;
    endcase
  end

  // MEM/WB register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      memwb_q <= '0;
    end else if (advance) begin
      memwb_q.rd      <= exmem.instr.rd;
      memwb_q.u_imm   <= exmem.instr.u_imm;
      memwb_q.ctrl    <= exmem.ctrl;
      memwb_q.alu_out <= exmem.alu_out;
      memwb_q.mdr     <= load_data;
    end
  end

  assign wb.we = memwb_q.ctrl.regfile_ld;
  assign wb.rd = memwb_q.rd;

  always_comb begin
    case (memwb_q.ctrl.wb_sel)
      wb_uimm: wb.data = memwb_q.u_imm;
      wb_mdr:  wb.data = memwb_q.mdr;
      default: wb.data = memwb_q.alu_out;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage import rv32i_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            advance,
  input  instr_t          instr,
  input  ctrl_word_t      ctrl,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output exmem_t          exmem
);

  idex_t           idex_q;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_out;

  // ID/EX register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idex_q <= '0;
    end else if (advance) begin
      idex_q.instr    <= instr;
      idex_q.ctrl     <= ctrl;
      idex_q.rs1_data <= rs1_data;
      idex_q.rs2_data <= rs2_data;
    end
  end

  assign imm   = (idex_q.ctrl.imm_sel == IMM_S) ? idex_q.instr.s_imm : idex_q.instr.i_imm;
  assign alu_b = (idex_q.ctrl.alumux2_sel == ALUMUX2_IMM) ? imm : idex_q.rs2_data;

  always_comb begin
    case (idex_q.ctrl.alu_op)
      alu_add: alu_out = idex_q.rs1_data + alu_b;
      alu_sub: alu_out = idex_q.rs1_data - alu_b;
      alu_slt: alu_out = {{(XLEN-1){1'b0}}, $signed(idex_q.rs1_data) < $signed(alu_b)};
      alu_xor: alu_out = idex_q.rs1_data ^ alu_b;
      alu_or:  alu_out = idex_q.rs1_data | alu_b;
      alu_and: alu_out = idex_q.rs1_data & alu_b;
      default: alu_out = idex_q.rs1_data + alu_b;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exmem <= '0;
    end else if (advance) begin
      exmem.instr    <= idex_q.instr;
      exmem.ctrl     <= idex_q.ctrl;
      exmem.alu_out  <= alu_out;
      exmem.rs2_data <= idex_q.rs2_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile import rv32i_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wb_t                   wb,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data
);

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            wr_en;

  // x0 is never written, so it reads back zero
  assign wr_en = wb.we && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-through so decode sees a same-cycle writeback
  assign rs1_data = (wr_en && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
  assign rs2_data = (wr_en && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== src/ctrl_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_rom import rv32i_pkg::*; (
  input  instr_t     instr,
  output ctrl_word_t ctrl
);

  alu_op_t arith_op;
  logic    arith_ok;

  // Shared funct3 map for immediate and register operations
  always_comb begin
    arith_ok = 1'b1;
    case (instr.funct3)
      3'b000: begin
        // Only register ops honour funct7 for sub
        if (instr.opcode == op_reg && instr.funct7[5]) begin
          arith_op = alu_sub;
        end else begin
          arith_op = alu_add;
        end
      end
      3'b010: arith_op = alu_slt;
      3'b100: arith_op = alu_xor;
      3'b110: arith_op = alu_or;
      3'b111: arith_op = alu_and;
      default: begin
        // Shifts and sltu fall out as no-ops
        arith_op = alu_add;
        arith_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (instr.opcode)
      op_lui: begin
        ctrl.wb_sel     = wb_uimm;
        ctrl.regfile_ld = 1'b1;
      end
      op_load: begin
        ctrl.alu_op      = alu_add;
        ctrl.alumux2_sel = ALUMUX2_IMM;
        ctrl.imm_sel     = IMM_I;
        ctrl.wb_sel      = wb_mdr;
        ctrl.regfile_ld  = 1'b1;
        ctrl.dcache_read = 1'b1;
      end
      op_store: begin
        ctrl.alu_op       = alu_add;
        ctrl.alumux2_sel  = ALUMUX2_IMM;
        ctrl.imm_sel      = IMM_S;
        ctrl.dcache_write = 1'b1;
      end
      op_imm: begin
        ctrl.alu_op      = arith_op;
        ctrl.alumux2_sel = ALUMUX2_IMM;
        ctrl.imm_sel     = IMM_I;
        ctrl.wb_sel      = wb_alu;
        ctrl.regfile_ld  = arith_ok;
      end
      op_reg: begin
        ctrl.alu_op      = arith_op;
        ctrl.alumux2_sel = ALUMUX2_RS2;
        ctrl.wb_sel      = wb_alu;
        ctrl.regfile_ld  = arith_ok;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import rv32i_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            icache_resp,
  input  logic [XLEN-1:0] icache_rdata,
  input  logic            mem_busy,
  output logic            icache_read,
  output logic [XLEN-1:0] icache_address,
  output logic            advance,
  output instr_t          ifid_instr
);

  logic [XLEN-1:0] pc_q;

  function automatic instr_t decode_instr(input logic [XLEN-1:0] word);
    instr_t d;
    d.opcode = rv32i_opcode_t'(word[6:0]);
    d.funct3 = word[14:12];
    d.funct7 = word[31:25];
    d.rs1    = word[19:15];
    d.rs2    = word[24:20];
    d.rd     = word[11:7];
    d.i_imm  = {{21{word[31]}}, word[30:20]};
    d.s_imm  = {{21{word[31]}}, word[30:25], word[11:7]};
    d.u_imm  = {word[31:12], 12'h000};
    return d;
  endfunction

  // Fetch is always requested once out of reset
  assign icache_read    = rst_n;
  assign icache_address = {pc_q[XLEN-1:2], 2'b00};

  // Whole pipeline freezes on either cache wait
  assign advance = ~(icache_read & ~icache_resp) & ~mem_busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q       <= PC_RESET;
      ifid_instr <= '0;
    end else if (advance) begin
      pc_q       <= pc_q + PC_STEP;
      ifid_instr <= decode_instr(icache_rdata);
    end
  end

endmodule

`default_nettype wire

// ==== src/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int MBE_W      = 4;

  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

  // Second ALU operand and immediate format selects
  localparam logic ALUMUX2_RS2 = 1'b0;
  localparam logic ALUMUX2_IMM = 1'b1;
  localparam logic IMM_I       = 1'b0;
  localparam logic IMM_S       = 1'b1;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_slt, alu_xor, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu, wb_uimm, wb_mdr
  } wb_sel_t;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct3_t;

  typedef struct packed {
    rv32i_opcode_t         opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       s_imm;
    logic [XLEN-1:0]       u_imm;
  } instr_t;

  // All zero means no register write and no memory access
  typedef struct packed {
    alu_op_t alu_op;
    logic    alumux2_sel;
    logic    imm_sel;
    wb_sel_t wb_sel;
    logic    regfile_ld;
    logic    dcache_read;
    logic    dcache_write;
  } ctrl_word_t;

  typedef struct packed {
    instr_t          instr;
    ctrl_word_t      ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
  } idex_t;

  typedef struct packed {
    instr_t          instr;
    ctrl_word_t      ctrl;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] rs2_data;
  } exmem_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       u_imm;
    ctrl_word_t            ctrl;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       mdr;
  } memwb_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire
